/* design/aluPkg.sv */
/* ALU shared definitions
   opcode encoding and opcode width used on every opcode port */
`default_nettype none

package aluPkg;

  //////////////////////////////////////////////////////////////////////
  // opcode
  //////////////////////////////////////////////////////////////////////

  // width of the opcode field on ports
  localparam int opWidth = 3;

  // eight operations, encoded 0 to 7 in this order
  typedef enum logic [opWidth-1:0] {
    opAdd   = 3'd0,
    opSub   = 3'd1,
    opAnd   = 3'd2,
    opOr    = 3'd3,
    opXor   = 3'd4,
    // shift left, zeros filled in from the bottom
    opShl   = 3'd5,
    // rotate right, low bits wrap to the top
    opRor   = 3'd6,
    opPassB = 3'd7
  } aluOp_t;

endpackage

`default_nettype wire

/* design/aluOperandLatch.sv */
/* ALU operand latch
   captures both operands and the opcode on a start strobe */
`timescale 1ns/10ps
`default_nettype none

module aluOperandLatch #(
  parameter int dataWidth = 8
) (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  start,
  input  wire [dataWidth-1:0]  opA,
  input  wire [dataWidth-1:0]  opB,
  input  wire aluPkg::aluOp_t  opCode,
  output logic [dataWidth-1:0] latA,
  output logic [dataWidth-1:0] latB,
  output aluPkg::aluOp_t       latOp,
  output logic                 rotateRight,
  output logic                 latValid
);

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  // one valid cycle per start, opcode and direction follow the strobe
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      latValid    <= 1'b0;
      latOp       <= aluPkg::opAdd;
      rotateRight <= 1'b0;
    end
    else
    begin
      latValid <= start;
      if (start)
      begin
        latOp       <= opCode;
        rotateRight <= (opCode == aluPkg::opRor);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operands
  //////////////////////////////////////////////////////////////////////

  // held until the next start
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      latA <= opA;
      latB <= opB;
    end
  end

  // an unknown opcode on a start would poison the whole datapath
  opCodeKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    start |-> !$isunknown(opCode)
  ) else $error("opcode unknown while start is high");

endmodule

`default_nettype wire

/* design/aluBarrelShifter.sv */
/* ALU barrel shifter
   shift left or rotate right by a decoded amount, with carry out */
`timescale 1ns/10ps
`default_nettype none

module aluBarrelShifter #(
  parameter int dataWidth = 8,
  localparam int shiftW = $clog2(dataWidth)
) (
  input  wire [dataWidth-1:0]  shiftIn,
  input  wire [shiftW-1:0]     shiftAmount,
  input  wire                  rotateRight,
  output logic [dataWidth-1:0] shiftOut,
  output logic                 shiftCarry
);

  // one spare bit on top of the data keeps the carry
  logic [dataWidth:0]   netIn;
  logic [dataWidth:0]   netOut;
  logic [dataWidth:0]   oriented;
  logic [dataWidth-1:0] amountHot;
  // bits that fall off the bottom on rotate and come back at the top
  logic [dataWidth-1:0] wrapBits;

  function automatic logic [dataWidth:0] reverseBits(input logic [dataWidth:0] v);
    logic [dataWidth:0] r;
    for (int i = 0; i <= dataWidth; i++)
    begin
      r[i] = v[dataWidth-i];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // amount decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int k = 0; k < dataWidth; k++)
    begin
      amountHot[k] = (shiftAmount == shiftW'(k));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // shift network
  //////////////////////////////////////////////////////////////////////

  // rotate runs through the left network on the reversed operand
  assign netIn = rotateRight ? reverseBits({shiftIn, 1'b0}) : {1'b0, shiftIn};

  // OR of ANDs, bit j picks up bit j-k when amount is k
  always_comb
  begin
    for (int j = 0; j <= dataWidth; j++)
    begin
      netOut[j] = 1'b0;
      for (int k = 0; k < dataWidth; k++)
      begin
        if (k <= j)
          netOut[j] = netOut[j] | (netIn[j-k] & amountHot[k]);
      end
    end
  end

  // low bits of the operand reappear at the top on a rotate
  always_comb
  begin
    wrapBits = '0;
    for (int i = 0; i < dataWidth; i++)
    begin
      for (int k = 1; k < dataWidth; k++)
      begin
        if (i + k >= dataWidth)
          wrapBits[i] = wrapBits[i] | (shiftIn[i+k-dataWidth] & amountHot[k]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output
  //////////////////////////////////////////////////////////////////////

  assign oriented = rotateRight ? reverseBits(netOut) : netOut;

  // on rotate bit 0 of the oriented word is the last bit moved out
  assign shiftOut   = rotateRight ? (oriented[dataWidth:1] | wrapBits)
                                  : oriented[dataWidth-1:0];
  assign shiftCarry = rotateRight ? oriented[0] : oriented[dataWidth];

endmodule

`default_nettype wire

/* design/aluArithLogic.sv */
/* ALU arithmetic and logic block
   add, subtract, bitwise ops and pass, with carry */
`timescale 1ns/10ps
`default_nettype none

module aluArithLogic #(
  parameter int dataWidth = 8
) (
  input  wire [dataWidth-1:0]  a,
  input  wire [dataWidth-1:0]  b,
  input  wire aluPkg::aluOp_t  op,
  output logic [dataWidth-1:0] arithOut,
  output logic                 arithCarry
);

  logic                 isSub;
  logic [dataWidth-1:0] bOperand;
  // one extra bit for the carry out
  logic [dataWidth:0]   sum;

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  assign isSub    = (op == aluPkg::opSub);
  // subtract as a + ~b + 1, carry set means no borrow
  assign bOperand = isSub ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, bOperand} + {{dataWidth{1'b0}}, isSub};

  //////////////////////////////////////////////////////////////////////
  // select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    arithOut   = '0;
    arithCarry = 1'b0;
    case (op)
      aluPkg::opAdd,
      aluPkg::opSub:
      begin
        arithOut   = sum[dataWidth-1:0];
        arithCarry = sum[dataWidth];
      end
      aluPkg::opAnd:
        arithOut = a & b;
      aluPkg::opOr:
        arithOut = a | b;
      aluPkg::opXor:
        arithOut = a ^ b;
      aluPkg::opPassB:
        arithOut = b;
      // shifts are taken from the shifter path
      default:
      begin
        arithOut   = '0;
        arithCarry = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/aluResultStage.sv */
/* ALU result stage
   picks the result path, derives flags, registers them and pulses done */
`timescale 1ns/10ps
`default_nettype none

module aluResultStage #(
  parameter int dataWidth = 8
) (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  stageValid,
  input  wire aluPkg::aluOp_t  op,
  input  wire [dataWidth-1:0]  shiftOut,
  input  wire                  shiftCarry,
  input  wire [dataWidth-1:0]  arithOut,
  input  wire                  arithCarry,
  output logic [dataWidth-1:0] result,
  output logic                 carry,
  output logic                 zero,
  output logic                 negative,
  output logic                 done
);

  logic                 useShift;
  logic [dataWidth-1:0] selResult;
  logic                 selCarry;

  //////////////////////////////////////////////////////////////////////
  // path select
  //////////////////////////////////////////////////////////////////////

  assign useShift  = (op == aluPkg::opShl) || (op == aluPkg::opRor);
  assign selResult = useShift ? shiftOut : arithOut;
  assign selCarry  = useShift ? shiftCarry : arithCarry;

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // result and flags hold until the next valid stage
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      result   <= '0;
      carry    <= 1'b0;
      zero     <= 1'b0;
      negative <= 1'b0;
    end
    else if (stageValid)
    begin
      result   <= selResult;
      carry    <= selCarry;
      zero     <= (selResult == '0);
      negative <= selResult[dataWidth-1];
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      done <= 1'b0;
    else
      done <= stageValid;
  end

  // a valid stage has to bring known opcode and data into the output registers
  resultKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    stageValid |-> !$isunknown({op, selResult, selCarry})
  ) else $error("result path unknown while the stage is valid");

endmodule

`default_nettype wire

/* design/aluUnit.sv */
/* ALU unit top level
   operand latch, shifter, arithmetic block and result stage */
`timescale 1ns/10ps
`default_nettype none

module aluUnit #(
  parameter int dataWidth = 8,
  localparam int shiftW = $clog2(dataWidth)
) (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  start,
  input  wire [dataWidth-1:0]  opA,
  input  wire [dataWidth-1:0]  opB,
  input  wire aluPkg::aluOp_t  opCode,
  output logic [dataWidth-1:0] result,
  output logic                 carry,
  output logic                 zero,
  output logic                 negative,
  output logic                 done
);

  // latched stage
  logic [dataWidth-1:0] latA;
  logic [dataWidth-1:0] latB;
  aluPkg::aluOp_t       latOp;
  logic                 rotateRight;
  logic                 latValid;

  // processing results
  logic [dataWidth-1:0] shiftOut;
  logic                 shiftCarry;
  logic [dataWidth-1:0] arithOut;
  logic                 arithCarry;

  aluOperandLatch #(.dataWidth(dataWidth)) latch0 (
    .clk(clk), .arstN(arstN), .start(start),
    .opA(opA), .opB(opB), .opCode(opCode),
    .latA(latA), .latB(latB), .latOp(latOp),
    .rotateRight(rotateRight), .latValid(latValid)
  );

  // shift amount is the low bits of operand b
  aluBarrelShifter #(.dataWidth(dataWidth)) shifter0 (
    .shiftIn(latA), .shiftAmount(latB[shiftW-1:0]), .rotateRight(rotateRight),
    .shiftOut(shiftOut), .shiftCarry(shiftCarry)
  );

  aluArithLogic #(.dataWidth(dataWidth)) arith0 (
    .a(latA), .b(latB), .op(latOp),
    .arithOut(arithOut), .arithCarry(arithCarry)
  );

  aluResultStage #(.dataWidth(dataWidth)) result0 (
    .clk(clk), .arstN(arstN), .stageValid(latValid), .op(latOp),
    .shiftOut(shiftOut), .shiftCarry(shiftCarry),
    .arithOut(arithOut), .arithCarry(arithCarry),
    .result(result), .carry(carry), .zero(zero),
    .negative(negative), .done(done)
  );

endmodule

`default_nettype wire

/* testbench/aluRefModel.svh */
/* ALU reference model
   expected result and flags from the operation rules, plus the directed stimulus table */
`ifndef aluRefModelSvh
`define aluRefModelSvh

//////////////////////////////////////////////////////////////////////
// directed table
//////////////////////////////////////////////////////////////////////

// columns: opcode, a, b, expected result, expected carry
localparam int numDirected = 31;

localparam logic [27:0] directedTable [numDirected] = '{
  {aluPkg::opAdd,   8'hFF, 8'h01, 8'h00, 1'b1},
  {aluPkg::opAdd,   8'h12, 8'h34, 8'h46, 1'b0},
  {aluPkg::opAdd,   8'h80, 8'h80, 8'h00, 1'b1},
  {aluPkg::opSub,   8'h05, 8'h07, 8'hFE, 1'b0},
  {aluPkg::opSub,   8'h07, 8'h05, 8'h02, 1'b1},
  {aluPkg::opSub,   8'h42, 8'h42, 8'h00, 1'b1},
  {aluPkg::opAnd,   8'hF0, 8'h3C, 8'h30, 1'b0},
  {aluPkg::opOr,    8'hF0, 8'h0C, 8'hFC, 1'b0},
  {aluPkg::opXor,   8'hAA, 8'hFF, 8'h55, 1'b0},
  {aluPkg::opPassB, 8'h12, 8'hA5, 8'hA5, 1'b0},
  {aluPkg::opPassB, 8'hFF, 8'h00, 8'h00, 1'b0},
  // shift left of 1011_0101 by 0 to 7
  {aluPkg::opShl,   8'hB5, 8'h00, 8'hB5, 1'b0},
  {aluPkg::opShl,   8'hB5, 8'h01, 8'h6A, 1'b1},
  {aluPkg::opShl,   8'hB5, 8'h02, 8'hD4, 1'b0},
  {aluPkg::opShl,   8'hB5, 8'h03, 8'hA8, 1'b1},
  {aluPkg::opShl,   8'hB5, 8'h04, 8'h50, 1'b1},
  {aluPkg::opShl,   8'hB5, 8'h05, 8'hA0, 1'b0},
  {aluPkg::opShl,   8'hB5, 8'h06, 8'h40, 1'b1},
  {aluPkg::opShl,   8'hB5, 8'h07, 8'h80, 1'b0},
  // rotate right of the same pattern
  {aluPkg::opRor,   8'hB5, 8'h00, 8'hB5, 1'b0},
  {aluPkg::opRor,   8'hB5, 8'h01, 8'hDA, 1'b1},
  {aluPkg::opRor,   8'hB5, 8'h02, 8'h6D, 1'b0},
  {aluPkg::opRor,   8'hB5, 8'h03, 8'hB6, 1'b1},
  {aluPkg::opRor,   8'hB5, 8'h04, 8'h5B, 1'b0},
  {aluPkg::opRor,   8'hB5, 8'h05, 8'hAD, 1'b1},
  {aluPkg::opRor,   8'hB5, 8'h06, 8'hD6, 1'b1},
  {aluPkg::opRor,   8'hB5, 8'h07, 8'h6B, 1'b0},
  // upper bits of b are ignored by the shifts
  {aluPkg::opShl,   8'h01, 8'hF9, 8'h02, 1'b0},
  {aluPkg::opShl,   8'hFF, 8'h08, 8'hFF, 1'b0},
  {aluPkg::opRor,   8'h01, 8'h0F, 8'h02, 1'b0},
  {aluPkg::opRor,   8'h01, 8'h01, 8'h80, 1'b1}
};

//////////////////////////////////////////////////////////////////////
// reference function
//////////////////////////////////////////////////////////////////////

function automatic void refAlu(
  input  aluPkg::aluOp_t       op,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  output logic [dataWidth-1:0] res,
  output logic                 c,
  output logic                 z,
  output logic                 n
);
  int                     amount;
  logic [dataWidth:0]     sum;
  logic [2*dataWidth-1:0] doubled;
  logic [dataWidth-1:0]   moved;
  amount = int'(b) % dataWidth;
  res = '0;
  c = 1'b0;
  case (op)
    aluPkg::opAdd:
    begin
      sum = {1'b0, a} + {1'b0, b};
      res = sum[dataWidth-1:0];
      c = sum[dataWidth];
    end
    aluPkg::opSub:
    begin
      res = a - b;
      // carry means no borrow
      c = (a >= b);
    end
    aluPkg::opAnd:
      res = a & b;
    aluPkg::opOr:
      res = a | b;
    aluPkg::opXor:
      res = a ^ b;
    aluPkg::opShl:
    begin
      res = a << amount;
      if (amount > 0)
      begin
        // last bit pushed out of the top
        moved = a >> (dataWidth - amount);
        c = moved[0];
      end
    end
    aluPkg::opRor:
    begin
      doubled = {a, a} >> amount;
      res = doubled[dataWidth-1:0];
      if (amount > 0)
      begin
        moved = a >> (amount - 1);
        c = moved[0];
      end
    end
    aluPkg::opPassB:
      res = b;
    default:
      res = '0;
  endcase
  z = (res == '0);
  n = res[dataWidth-1];
endfunction

`endif

/* testbench/aluUnitTb.sv */
/* ALU unit testbench
   directed, back-to-back and random operations checked against a reference model */
`timescale 1ns/10ps
`default_nettype none

module aluUnitTb;

  localparam int dataWidth     = 8;
  localparam int timeoutCycles = 20;
  localparam int numRandom     = 200;

  `include "aluRefModel.svh"

  logic                 clk = 1'b0;
  logic                 arstN;
  logic                 start;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  aluPkg::aluOp_t       opCode;
  logic [dataWidth-1:0] result;
  logic                 carry;
  logic                 zero;
  logic                 negative;
  logic                 done;

  // outstanding operations, oldest first
  logic [dataWidth-1:0] expResultQ[$];
  logic [2:0]           expFlagsQ[$];
  int                   dueCycleQ[$];
  string                nameQ[$];

  int     cycleCount   = 0;
  int     errorCount   = 0;
  int     otherCount   = 0;
  int     timeoutCount = 0;
  integer seed         = 32'h6f78;

  aluUnit #(.dataWidth(dataWidth)) dut0 (
    .clk(clk), .arstN(arstN), .start(start),
    .opA(opA), .opB(opB), .opCode(opCode),
    .result(result), .carry(carry), .zero(zero),
    .negative(negative), .done(done)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("** Error %s %s: expected 0x%0h, actual 0x%0h", testName, field, expected, actual);
      errorCount++;
    end
  endtask

  task automatic completeOperation();
    logic [dataWidth-1:0] expRes;
    logic [2:0]           expFlags;
    int                   due;
    string                testName;
    assert (expResultQ.size() != 0)
    else
    begin
      $display("done pulse at cycle %0d with no operation outstanding", cycleCount);
      otherCount++;
    end
    if (expResultQ.size() != 0)
    begin
      expRes   = expResultQ.pop_front();
      expFlags = expFlagsQ.pop_front();
      due      = dueCycleQ.pop_front();
      testName = nameQ.pop_front();
      checkValue(testName, "result", 32'(expRes), 32'(result));
      checkValue(testName, "carry", 32'(expFlags[2]), 32'(carry));
      checkValue(testName, "zero", 32'(expFlags[1]), 32'(zero));
      checkValue(testName, "negative", 32'(expFlags[0]), 32'(negative));
      checkValue(testName, "done cycle", 32'(due), 32'(cycleCount));
    end
  endtask

  // outputs are settled half a period after the edge
  always @(negedge clk)
  begin
    if (arstN && done)
      completeOperation();
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic issueOp(input aluPkg::aluOp_t op, input logic [dataWidth-1:0] a,
                         input logic [dataWidth-1:0] b, input string testName);
    logic [dataWidth-1:0] expRes;
    logic                 expC;
    logic                 expZ;
    logic                 expN;
    refAlu(op, a, b, expRes, expC, expZ, expN);
    expResultQ.push_back(expRes);
    expFlagsQ.push_back({expC, expZ, expN});
    // sampled at the next edge, done shows after the one after that
    dueCycleQ.push_back(cycleCount + 2);
    nameQ.push_back(testName);
    start  = 1'b1;
    opA    = a;
    opB    = b;
    opCode = op;
    nextCycle();
  endtask

  task automatic waitDrained(input string phase);
    int waited;
    waited = 0;
    while (expResultQ.size() != 0 && waited < timeoutCycles)
    begin
      nextCycle();
      waited++;
    end
    if (expResultQ.size() != 0)
    begin
      $display("timeout in %s phase, %0d operations got no done pulse within %0d cycles",
               phase, expResultQ.size(), timeoutCycles);
      timeoutCount++;
    end
  endtask

  task automatic applyReset();
    arstN  = 1'b0;
    start  = 1'b0;
    opA    = '0;
    opB    = '0;
    opCode = aluPkg::opAdd;
    repeat (16) @(posedge clk);
    #1;
    arstN = 1'b1;
  endtask

  task automatic checkResetState();
    for (int i = 0; i < 4; i++)
    begin
      checkValue("reset", "done", 32'h0, 32'(done));
      checkValue("reset", "result", 32'h0, 32'(result));
      checkValue("reset", "carry", 32'h0, 32'(carry));
      checkValue("reset", "zero", 32'h0, 32'(zero));
      checkValue("reset", "negative", 32'h0, 32'(negative));
      nextCycle();
    end
  endtask

  task automatic runDirected();
    logic [27:0]          entry;
    aluPkg::aluOp_t       op;
    logic [dataWidth-1:0] refRes;
    logic                 refC;
    logic                 refZ;
    logic                 refN;
    for (int i = 0; i < numDirected; i++)
    begin
      entry = directedTable[i];
      op    = aluPkg::aluOp_t'(entry[27:25]);
      // hand-derived entry and model have to agree
      refAlu(op, entry[24:17], entry[16:9], refRes, refC, refZ, refN);
      assert ({refRes, refC} === entry[8:0])
      else
      begin
        $display("reference model disagrees with directed entry %0d", i);
        otherCount++;
      end
      issueOp(op, entry[24:17], entry[16:9], $sformatf("directed%0d %s", i, op.name()));
      start = 1'b0;
      waitDrained("directed");
      if (timeoutCount != 0)
        break;
    end
  endtask

  // starts on consecutive cycles, two operations in flight
  task automatic runBackToBack();
    issueOp(aluPkg::opAdd, 8'h7F, 8'h01, "b2b add");
    issueOp(aluPkg::opRor, 8'h81, 8'h03, "b2b ror");
    issueOp(aluPkg::opSub, 8'h10, 8'h20, "b2b sub");
    issueOp(aluPkg::opXor, 8'h3C, 8'h3C, "b2b xor");
    issueOp(aluPkg::opShl, 8'hC3, 8'h02, "b2b shl");
    start = 1'b0;
    waitDrained("back-to-back");
  endtask

  task automatic runRandom();
    logic [31:0]    rnd;
    aluPkg::aluOp_t op;
    for (int i = 0; i < numRandom; i++)
    begin
      rnd = $random(seed);
      op  = aluPkg::aluOp_t'(rnd[2:0]);
      issueOp(op, rnd[8 +: dataWidth], rnd[16 +: dataWidth],
              $sformatf("random%0d %s", i, op.name()));
      // roughly one start in four gets an idle cycle behind it
      if (rnd[31:30] == 2'b00)
      begin
        start = 1'b0;
        nextCycle();
      end
    end
    start = 1'b0;
    waitDrained("random");
  endtask

  task automatic finishRun();
    $display("summary: %0d wrong values, %0d other failures, %0d timeouts",
             errorCount, otherCount, timeoutCount);
    if (errorCount == 0 && otherCount == 0 && timeoutCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  initial
  begin
    applyReset();
    checkResetState();
    runDirected();
    if (timeoutCount == 0)
      runBackToBack();
    if (timeoutCount == 0)
      runRandom();
    // a stray done pulse would still show up here
    repeat (3) nextCycle();
    finishRun();
  end

endmodule

`default_nettype wire

/* aluUnit.f */
+incdir+testbench
design/aluPkg.sv
design/aluOperandLatch.sv
design/aluBarrelShifter.sv
design/aluArithLogic.sv
design/aluResultStage.sv
design/aluUnit.sv
testbench/aluUnitTb.sv

/* runSim.sh */
#!/bin/sh
# build the ALU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f aluUnit.f --top-module aluUnitTb -o aluUnitSim

status=0
./obj_dir/aluUnitSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
